// ==== hdl/snq_cfg_pkg.sv ====
// snoop queue entry configuration
// widths of the stored address and dependency vector, and the
// one-hot encoding of the snoop-tag state machine
package snq_cfg_pkg;

  // --------------------------------------------------------------------------
  // address widths
  // --------------------------------------------------------------------------
  // physical address
  localparam int pa_width        = 40;
  // 16-byte aligned line address kept in the entry
  localparam int line_addr_width = pa_width - 4;
  // index bits compared against wmb / lfb / vb requests
  localparam int idx_width       = 8;

  // --------------------------------------------------------------------------
  // issue dependency layout
  // --------------------------------------------------------------------------
  // bits 0..1 victim buffers, bits 2..9 wmb entries
  localparam int vb_num     = 2;
  localparam int wmb_num    = 8;
  localparam int depd_width = vb_num + wmb_num;

  // --------------------------------------------------------------------------
  // snoop-tag fsm, one hot
  // --------------------------------------------------------------------------
  // idle is all zero so the fsm leaves reset with no bit set
  typedef enum logic [4:0] {
    snpt_idle           = 5'b00000,
    // waiting for victim buffers to drain
    snpt_wait_vb        = 5'b00001,
    snpt_wait_resp      = 5'b00010,
    snpt_sdt_req        = 5'b00100,
    snpt_wait_sdt_cmplt = 5'b01000,
    // response ready, waits for bus accept
    snpt_wait_pop       = 5'b10000
  } snpt_state_t;

endpackage

// ==== hdl/snq_proto_pkg.sv ====
// snoop protocol definitions
// snoop type codes, the coherence response word, the dcache tag
// response and the bundles passed in and out of a snoop queue entry
package snq_proto_pkg;

  // --------------------------------------------------------------------------
  // snoop request types
  // --------------------------------------------------------------------------
  typedef enum logic [3:0] {
    read_once     = 4'b0000,
    read_shared   = 4'b0001,
    read_unique   = 4'b0111,
    clean_shared  = 4'b1000,
    clean_invalid = 4'b1001,
    make_invalid  = 4'b1101
  } snoop_type_t;

  // coherence response, msb first
  typedef struct packed {
    logic was_unique;
    logic is_shared;
    logic pass_dirty;
    logic error;
    logic data_transfer;
  } cr_resp_t;

  // dcache tag lookup result
  typedef struct packed {
    logic valid;
    logic dirty;
    logic share;
    logic way;
  } tag_resp_t;

  // entry create bundle
  typedef struct packed {
    logic [snq_cfg_pkg::pa_width-1:0]   addr;
    logic [snq_cfg_pkg::depd_width-1:0] depd;
    snoop_type_t                        snp_type;
  } snq_create_t;

  // work left for the snoop data stage after the tag read
  typedef struct packed {
    logic read_data;
    logic chg_tag_s;
    logic chg_tag_i;
    logic chg_tag;
  } snpdt_need_t;

  // index hits against other lsu buffers
  typedef struct packed {
    logic wmb_write;
    logic wmb_read;
    logic lfb_vb;
  } hit_idx_t;

endpackage

// ==== hdl/snq_entry_ctrl.sv ====
// snoop queue entry control
// entry valid, tag issued flag and the snoop-tag state machine that
// walks tag read, data/tag change, vb wait and response pop
`timescale 1ns/10ps

module snq_entry_ctrl (
  input  logic snqctrlclk,
  input  logic cpurst_b,
  input  logic create_en,
  input  logic depd_clear,
  input  logic wait_vb,
  input  logic need_snpdt,
  input  logic tag_start,
  input  logic tag_grnt,
  input  logic resp_create_en,
  input  logic snpdt_grnt,
  input  logic snpdt_cmplt,
  input  logic oldest,
  input  logic cr_resp_accept,
  output logic vld,
  output logic issued,
  output logic rd_tag_rdy,
  output logic tag_req,
  output logic snpdt_start,
  output logic cr_resp_valid,
  output logic save_resp
);

  snq_cfg_pkg::snpt_state_t snpt_cur_state;
  snq_cfg_pkg::snpt_state_t snpt_next_state;
  logic                     snpt_idle_st;
  logic                     tag_issued;

  // --------------------------------------------------------------------------
  // valid and issued
  // --------------------------------------------------------------------------
  // bus accept of the response retires the entry
  always_ff @(posedge snqctrlclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      vld <= 1'b0;
    else if (create_en)
      vld <= 1'b1;
    else if (cr_resp_accept)
      vld <= 1'b0;
  end

  assign snpt_idle_st = (snpt_cur_state == snq_cfg_pkg::snpt_idle);
  assign tag_issued   = tag_start && tag_grnt && snpt_idle_st;

  always_ff @(posedge snqctrlclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      issued <= 1'b0;
    else if (cr_resp_accept)
      issued <= 1'b0;
    else if (tag_issued)
      issued <= 1'b1;
  end

  // ready for tag read once every dependency has gone
  assign rd_tag_rdy = vld && depd_clear && !issued;

  // --------------------------------------------------------------------------
  // snoop-tag fsm
  // --------------------------------------------------------------------------
  always_ff @(posedge snqctrlclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      snpt_cur_state <= snq_cfg_pkg::snpt_idle;
    else
      snpt_cur_state <= snpt_next_state;
  end

  always_comb
  begin
    snpt_next_state = snpt_cur_state;
    case (snpt_cur_state)
      snq_cfg_pkg::snpt_idle:
        if (tag_start && tag_grnt)
          snpt_next_state = snq_cfg_pkg::snpt_wait_resp;
      snq_cfg_pkg::snpt_wait_resp:
        // tag back, pick next step from the decoded needs
        if (resp_create_en)
        begin
          if (need_snpdt)
            snpt_next_state = snq_cfg_pkg::snpt_sdt_req;
          else if (wait_vb)
            snpt_next_state = snq_cfg_pkg::snpt_wait_vb;
          else
            snpt_next_state = snq_cfg_pkg::snpt_wait_pop;
        end
      snq_cfg_pkg::snpt_sdt_req:
        if (snpdt_grnt && oldest)
          snpt_next_state = snq_cfg_pkg::snpt_wait_sdt_cmplt;
      snq_cfg_pkg::snpt_wait_sdt_cmplt:
        if (snpdt_cmplt)
          snpt_next_state = wait_vb ? snq_cfg_pkg::snpt_wait_vb
                                    : snq_cfg_pkg::snpt_wait_pop;
      snq_cfg_pkg::snpt_wait_vb:
        if (!wait_vb)
          snpt_next_state = snq_cfg_pkg::snpt_wait_pop;
      snq_cfg_pkg::snpt_wait_pop:
        if (cr_resp_accept)
          snpt_next_state = snq_cfg_pkg::snpt_idle;
      default:
        snpt_next_state = snq_cfg_pkg::snpt_idle;
    endcase
  end

  // request and pop strobes, only the oldest entry may go
  assign tag_req       = tag_start;
  assign save_resp     = resp_create_en;
  assign snpdt_start   = oldest && (snpt_cur_state == snq_cfg_pkg::snpt_sdt_req);
  assign cr_resp_valid = oldest && (snpt_cur_state == snq_cfg_pkg::snpt_wait_pop);

endmodule

// ==== hdl/snq_depd_track.sv ====
// snoop entry dependency tracking
// issue dependency vector on vb and wmb entries, plus the separate
// victim-buffer wait vector checked before the response pops
`timescale 1ns/10ps

module snq_depd_track (
  input  logic                                snqctrlclk,
  input  logic                                cpurst_b,
  input  logic                                create_en,
  input  logic [snq_cfg_pkg::depd_width-1:0]  create_depd,
  input  logic [snq_cfg_pkg::depd_width-1:0]  depd_remove,
  input  logic                                vld,
  input  logic                                vb_start_wait,
  input  logic [snq_cfg_pkg::vb_num-1:0]      vb_wait_id,
  input  logic [snq_cfg_pkg::vb_num-1:0]      vb_wait_remove,
  output logic [snq_cfg_pkg::depd_width-1:0]  depd,
  output logic                                depd_clear,
  output logic [snq_cfg_pkg::vb_num-1:0]      depd_vb_id,
  output logic                                wait_vb
);

  logic [snq_cfg_pkg::vb_num-1:0] wait_vb_vec;

  // --------------------------------------------------------------------------
  // issue dependency
  // --------------------------------------------------------------------------
  always_ff @(posedge snqctrlclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      depd <= '0;
    else if (create_en)
      depd <= create_depd;
    else
      depd <= depd & ~depd_remove;
  end

  assign depd_clear = ~|depd;

  // vb bits go out for evict deadlock avoidance
  assign depd_vb_id = {snq_cfg_pkg::vb_num{vld}} & depd[snq_cfg_pkg::vb_num-1:0];

  // --------------------------------------------------------------------------
  // victim buffer wait
  // --------------------------------------------------------------------------
  always_ff @(posedge snqctrlclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      wait_vb_vec <= '0;
    else if (vb_start_wait)
      wait_vb_vec <= vb_wait_id;
    else
      wait_vb_vec <= wait_vb_vec & ~vb_wait_remove;
  end

  assign wait_vb = |wait_vb_vec;

endmodule

// ==== hdl/snq_resp_decode.sv ====
// snoop response decode
// holds the snoop type, decodes the dcache tag response into the
// coherence response and data-stage needs, captures them on save
`timescale 1ns/10ps

module snq_resp_decode (
  input  logic                        snqctrlclk,
  input  logic                        cpurst_b,
  input  logic                        create_en,
  input  snq_proto_pkg::snoop_type_t  create_type,
  input  snq_proto_pkg::tag_resp_t    tag_resp,
  input  logic                        ecc_err,
  input  logic                        save_resp,
  output logic                        need_snpdt,
  output snq_proto_pkg::snpdt_need_t  need,
  output logic                        way,
  output snq_proto_pkg::cr_resp_t     cr_resp,
  output logic                        tag_req_for_inv
);

  snq_proto_pkg::snoop_type_t snp_type;
  snq_proto_pkg::cr_resp_t    resp_live;
  logic                       is_rs;
  logic                       is_ru;
  logic                       is_ro;
  logic                       is_cs;
  logic                       is_ci;
  logic                       is_mi;
  logic                       line_dirty;
  logic                       chg_tag_m;
  logic                       chg_tag_s;
  logic                       chg_tag_i;

  // snoop type of the request held by the entry
  always_ff @(posedge snqctrlclk)
  begin
    if (create_en)
      snp_type <= create_type;
  end

  assign is_rs = (snp_type == snq_proto_pkg::read_shared);
  assign is_ru = (snp_type == snq_proto_pkg::read_unique);
  assign is_ro = (snp_type == snq_proto_pkg::read_once);
  assign is_cs = (snp_type == snq_proto_pkg::clean_shared);
  assign is_ci = (snp_type == snq_proto_pkg::clean_invalid);
  assign is_mi = (snp_type == snq_proto_pkg::make_invalid);

  // --------------------------------------------------------------------------
  // response decode
  // --------------------------------------------------------------------------
  // only M lines transfer data, l2 is inclusive
  assign line_dirty = tag_resp.valid && tag_resp.dirty;

  assign resp_live.was_unique    = 1'b0;
  assign resp_live.is_shared     = tag_resp.valid && (is_rs || is_ro || is_cs);
  assign resp_live.pass_dirty    = line_dirty && (is_rs || is_ru || is_ci || is_cs);
  assign resp_live.error         = ecc_err;
  assign resp_live.data_transfer = line_dirty && (is_rs || is_ru || is_ro || is_ci || is_cs);

  // tag state changes, M always drops to clean
  assign chg_tag_m = line_dirty && is_cs;
  // E or M goes to shared
  assign chg_tag_s = tag_resp.valid && !tag_resp.share && (is_cs || is_rs);
  assign chg_tag_i = tag_resp.valid && (is_ru || is_ci || is_mi);

  assign need_snpdt = resp_live.data_transfer || chg_tag_m || chg_tag_s || chg_tag_i;

  assign tag_req_for_inv = is_ru || is_ci || is_mi;

  // --------------------------------------------------------------------------
  // capture on save
  // --------------------------------------------------------------------------
  always_ff @(posedge snqctrlclk)
  begin
    if (save_resp)
    begin
      cr_resp <= resp_live;
      way     <= tag_resp.way;
    end
  end

  // need flags steer the data stage
  always_ff @(posedge snqctrlclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      need <= '0;
    else if (save_resp)
    begin
      need.read_data <= resp_live.data_transfer;
      need.chg_tag_s <= chg_tag_s;
      need.chg_tag_i <= chg_tag_i;
      need.chg_tag   <= chg_tag_m || chg_tag_s || chg_tag_i;
    end
  end

endmodule

// ==== hdl/snq_addr_match.sv ====
// snoop entry address and index compare
// keeps the 16-byte aligned line address and flags index matches
// against wmb write/read requests and lfb/vb addresses
`timescale 1ns/10ps

module snq_addr_match (
  input  logic                                     snqctrlclk,
  input  logic                                     cpurst_b,
  input  logic                                     create_en,
  input  logic [snq_cfg_pkg::pa_width-1:0]         create_addr,
  input  logic                                     vld,
  input  logic [snq_cfg_pkg::depd_width-1:0]       depd,
  input  logic [snq_cfg_pkg::pa_width-1:0]         wmb_write_addr,
  input  logic [snq_cfg_pkg::wmb_num-1:0]          wmb_write_ptr,
  input  logic [snq_cfg_pkg::pa_width-1:0]         wmb_read_addr,
  input  logic [snq_cfg_pkg::pa_width-7:0]         lfb_vb_addr_tto6,
  output logic [snq_cfg_pkg::line_addr_width-1:0]  addr,
  output snq_proto_pkg::hit_idx_t                  hit
);

  logic [snq_cfg_pkg::idx_width-1:0] idx;
  logic                              wmb_ptr_free;

  // line address, drop the low 4 bits
  always_ff @(posedge snqctrlclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      addr <= '0;
    else if (create_en)
      addr <= create_addr[snq_cfg_pkg::pa_width-1:4];
  end

  // --------------------------------------------------------------------------
  // index compares
  // --------------------------------------------------------------------------
  // stored bits 9:2 are pa bits 13:6
  assign idx = addr[snq_cfg_pkg::idx_width+1:2];

  // a wmb write the entry already depends on is not a hit
  assign wmb_ptr_free = |(~depd[snq_cfg_pkg::depd_width-1:snq_cfg_pkg::vb_num]
                          & wmb_write_ptr);

  assign hit.wmb_write = vld && wmb_ptr_free
                         && (idx == wmb_write_addr[snq_cfg_pkg::idx_width+5:6]);
  assign hit.wmb_read  = vld && (idx == wmb_read_addr[snq_cfg_pkg::idx_width+5:6]);
  // tto6 address is already shifted down by 6
  assign hit.lfb_vb    = vld && (idx == lfb_vb_addr_tto6[snq_cfg_pkg::idx_width-1:0]);

endmodule

// ==== hdl/snq_entry_top.sv ====
// snoop queue entry
// one entry of the lsu coherence snoop queue: control fsm,
// dependency tracking, response decode and index compare
`timescale 1ns/10ps

module snq_entry_top (
  input  logic                                     snqctrlclk,
  input  logic                                     cpurst_b,
  input  logic                                     create_en,
  input  snq_proto_pkg::snq_create_t               create,
  input  logic [snq_cfg_pkg::depd_width-1:0]       depd_remove,
  input  logic                                     vb_start_wait,
  input  logic [snq_cfg_pkg::vb_num-1:0]           vb_wait_id,
  input  logic [snq_cfg_pkg::vb_num-1:0]           vb_wait_remove,
  input  logic                                     tag_start,
  input  logic                                     tag_grnt,
  input  logic                                     resp_create_en,
  input  snq_proto_pkg::tag_resp_t                 tag_resp,
  input  logic                                     ecc_err,
  input  logic                                     snpdt_grnt,
  input  logic                                     snpdt_cmplt,
  input  logic                                     oldest,
  input  logic                                     cr_resp_accept,
  input  logic [snq_cfg_pkg::pa_width-1:0]         wmb_write_addr,
  input  logic [snq_cfg_pkg::wmb_num-1:0]          wmb_write_ptr,
  input  logic [snq_cfg_pkg::pa_width-1:0]         wmb_read_addr,
  input  logic [snq_cfg_pkg::pa_width-7:0]         lfb_vb_addr_tto6,
  output logic                                     vld,
  output logic                                     rd_tag_rdy,
  output logic                                     tag_req,
  output logic                                     issued,
  output logic [snq_cfg_pkg::line_addr_width-1:0]  addr,
  output logic                                     tag_req_for_inv,
  output logic                                     snpdt_start,
  output snq_proto_pkg::snpdt_need_t               need,
  output logic                                     way,
  output logic                                     cr_resp_valid,
  output snq_proto_pkg::cr_resp_t                  cr_resp,
  output logic [snq_cfg_pkg::vb_num-1:0]           depd_vb_id,
  output snq_proto_pkg::hit_idx_t                  hit
);

  logic [snq_cfg_pkg::depd_width-1:0] depd;
  logic                               depd_clear;
  logic                               wait_vb;
  logic                               need_snpdt;
  logic                               save_resp;

  snq_entry_ctrl u_ctrl (
    .snqctrlclk, .cpurst_b, .create_en, .depd_clear, .wait_vb, .need_snpdt,
    .tag_start, .tag_grnt, .resp_create_en, .snpdt_grnt, .snpdt_cmplt,
    .oldest, .cr_resp_accept, .vld, .issued, .rd_tag_rdy, .tag_req,
    .snpdt_start, .cr_resp_valid, .save_resp
  );

  snq_depd_track u_depd (
    .snqctrlclk, .cpurst_b, .create_en, .create_depd(create.depd), .depd_remove,
    .vld, .vb_start_wait, .vb_wait_id, .vb_wait_remove, .depd, .depd_clear,
    .depd_vb_id, .wait_vb
  );

  snq_resp_decode u_resp (
    .snqctrlclk, .cpurst_b, .create_en, .create_type(create.snp_type), .tag_resp,
    .ecc_err, .save_resp, .need_snpdt, .need, .way, .cr_resp, .tag_req_for_inv
  );

  snq_addr_match u_addr (
    .snqctrlclk, .cpurst_b, .create_en, .create_addr(create.addr), .vld, .depd,
    .wmb_write_addr, .wmb_write_ptr, .wmb_read_addr, .lfb_vb_addr_tto6,
    .addr, .hit
  );

endmodule

// ==== tests/snq_entry_sva.sv ====
// snoop entry control assertions
// response pop and data request rules of the snoop-tag fsm
`timescale 1ns/10ps

module snq_entry_sva (
  input  logic                      snqctrlclk,
  input  logic                      cpurst_b,
  input  logic                      vld,
  input  logic                      snpdt_start,
  input  logic                      cr_resp_valid,
  input  logic                      cr_resp_accept
);

  // response only from a live entry
  a_resp_needs_vld: assert property (@(posedge snqctrlclk) disable iff (!cpurst_b)
    cr_resp_valid |-> vld)
    else $error("cr_resp_valid high on an invalid entry");

  // data request and pop never overlap
  a_sdt_pop_excl: assert property (@(posedge snqctrlclk) disable iff (!cpurst_b)
    !(snpdt_start && cr_resp_valid))
    else $error("snpdt_start and cr_resp_valid high together");

  a_accept_retires: assert property (@(posedge snqctrlclk) disable iff (!cpurst_b)
    cr_resp_valid && cr_resp_accept |=> !vld)
    else $error("vld still set after response accept");

endmodule

bind snq_entry_ctrl snq_entry_sva sva_i (
  .snqctrlclk(snqctrlclk), .cpurst_b(cpurst_b), .vld(vld), .snpdt_start(snpdt_start),
  .cr_resp_valid(cr_resp_valid), .cr_resp_accept(cr_resp_accept)
);

// ==== tests/tb_snq_entry.sv ====
// snoop queue entry testbench
// directed tests over reset, create, dependencies, both snoop
// flows, the vb wait and the wmb / lfb / vb index compares
`timescale 1ns/10ps

module tb_snq_entry;

  localparam int wait_limit = 64;

  logic                                     snqctrlclk;
  logic                                     cpurst_b;
  logic                                     create_en;
  snq_proto_pkg::snq_create_t               create;
  logic [snq_cfg_pkg::depd_width-1:0]       depd_remove;
  logic                                     vb_start_wait;
  logic [snq_cfg_pkg::vb_num-1:0]           vb_wait_id;
  logic [snq_cfg_pkg::vb_num-1:0]           vb_wait_remove;
  logic                                     tag_start;
  logic                                     tag_grnt;
  logic                                     resp_create_en;
  snq_proto_pkg::tag_resp_t                 tag_resp;
  logic                                     ecc_err;
  logic                                     snpdt_grnt;
  logic                                     snpdt_cmplt;
  logic                                     oldest;
  logic                                     cr_resp_accept;
  logic [snq_cfg_pkg::pa_width-1:0]         wmb_write_addr;
  logic [snq_cfg_pkg::wmb_num-1:0]          wmb_write_ptr;
  logic [snq_cfg_pkg::pa_width-1:0]         wmb_read_addr;
  logic [snq_cfg_pkg::pa_width-7:0]         lfb_vb_addr_tto6;
  logic                                     vld;
  logic                                     rd_tag_rdy;
  logic                                     tag_req;
  logic                                     issued;
  logic [snq_cfg_pkg::line_addr_width-1:0]  addr;
  logic                                     tag_req_for_inv;
  logic                                     snpdt_start;
  snq_proto_pkg::snpdt_need_t               need;
  logic                                     way;
  logic                                     cr_resp_valid;
  snq_proto_pkg::cr_resp_t                  cr_resp;
  logic [snq_cfg_pkg::vb_num-1:0]           depd_vb_id;
  snq_proto_pkg::hit_idx_t                  hit;
  int                                       err_cnt;

  snq_entry_top dut_i (.*);

  initial
  begin
    snqctrlclk = 1'b0;
    forever #2 snqctrlclk = ~snqctrlclk;
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------
  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected)
    begin
      err_cnt++;
      $display("FAILED time %0t ns: %s got 0x%0h expected 0x%0h",
               $time, name, actual, expected);
      $display("test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // inputs change here, 1 ns after the edge
  task automatic next_cycle();
    @(posedge snqctrlclk);
    #1;
  endtask

  // outputs are sampled 2 ns after the edge
  task automatic settle();
    #1;
  endtask

  function automatic logic [snq_cfg_pkg::pa_width-1:0] random_addr();
    logic [63:0] wide;
    wide = {$urandom(), $urandom()};
    return wide[snq_cfg_pkg::pa_width-1:0];
  endfunction

  // on_resp picks cr_resp_valid, else snpdt_start
  task automatic wait_for_strobe(input logic on_resp, input string name);
    int n;
    n = 0;
    settle();
    while (!(on_resp ? cr_resp_valid : snpdt_start) && n < wait_limit)
    begin
      next_cycle();
      settle();
      n++;
    end
    if (!(on_resp ? cr_resp_valid : snpdt_start))
    begin
      $display("timeout: %s never went high", name);
      $display("test failed");
      $fatal(1, "wait timeout");
    end
  endtask

  task automatic create_entry(input logic [snq_cfg_pkg::pa_width-1:0] a,
                              input logic [snq_cfg_pkg::depd_width-1:0] d,
                              input snq_proto_pkg::snoop_type_t t);
    next_cycle();
    create_en       = 1'b1;
    create.addr     = a;
    create.depd     = d;
    create.snp_type = t;
    next_cycle();
    create_en = 1'b0;
    settle();
    check_value("vld", 64'(vld), 64'(1'b1));
    // line address drops the 16-byte offset
    check_value("addr", 64'(addr), 64'(a[snq_cfg_pkg::pa_width-1:4]));
  endtask

  task automatic issue_tag();
    check_value("rd_tag_rdy", 64'(rd_tag_rdy), 64'(1'b1));
    next_cycle();
    tag_start = 1'b1;
    tag_grnt  = 1'b1;
    settle();
    check_value("tag_req", 64'(tag_req), 64'(1'b1));
    next_cycle();
    tag_start = 1'b0;
    tag_grnt  = 1'b0;
    settle();
    check_value("issued", 64'(issued), 64'(1'b1));
    check_value("rd_tag_rdy", 64'(rd_tag_rdy), 64'(1'b0));
  endtask

  task automatic return_tag(input snq_proto_pkg::tag_resp_t r, input logic e);
    next_cycle();
    resp_create_en = 1'b1;
    tag_resp       = r;
    ecc_err        = e;
    next_cycle();
    resp_create_en = 1'b0;
    tag_resp       = '0;
    ecc_err        = 1'b0;
    settle();
  endtask

  // grant then complete the data stage, oldest already high
  task automatic run_data_stage();
    wait_for_strobe(1'b0, "snpdt_start");
    next_cycle();
    snpdt_grnt = 1'b1;
    next_cycle();
    snpdt_grnt = 1'b0;
    settle();
    check_value("snpdt_start", 64'(snpdt_start), 64'(1'b0));
    next_cycle();
    snpdt_cmplt = 1'b1;
    next_cycle();
    snpdt_cmplt = 1'b0;
  endtask

  task automatic pop_response();
    next_cycle();
    cr_resp_accept = 1'b1;
    next_cycle();
    cr_resp_accept = 1'b0;
    oldest         = 1'b0;
    settle();
    check_value("vld", 64'(vld), 64'(1'b0));
    check_value("issued", 64'(issued), 64'(1'b0));
    check_value("cr_resp_valid", 64'(cr_resp_valid), 64'(1'b0));
  endtask

  task automatic compare_index(input logic [snq_cfg_pkg::pa_width-1:0] wr,
                               input logic [snq_cfg_pkg::pa_width-1:0] rd,
                               input logic [snq_cfg_pkg::pa_width-1:0] lv,
                               input logic [snq_cfg_pkg::wmb_num-1:0] ptr,
                               input logic [2:0] exp_hit);
    next_cycle();
    wmb_write_addr   = wr;
    wmb_read_addr    = rd;
    lfb_vb_addr_tto6 = lv[snq_cfg_pkg::pa_width-1:6];
    wmb_write_ptr    = ptr;
    settle();
    // order is wmb_write, wmb_read, lfb_vb
    check_value("hit", 64'(hit), 64'(exp_hit));
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------
  task automatic test_reset_create();
    settle();
    check_value("vld", 64'(vld), 64'(1'b0));
    check_value("issued", 64'(issued), 64'(1'b0));
    check_value("tag_req", 64'(tag_req), 64'(1'b0));
    check_value("snpdt_start", 64'(snpdt_start), 64'(1'b0));
    check_value("cr_resp_valid", 64'(cr_resp_valid), 64'(1'b0));
    create_entry(random_addr(), '0, snq_proto_pkg::read_once);
    check_value("rd_tag_rdy", 64'(rd_tag_rdy), 64'(1'b1));
  endtask

  task automatic test_dependencies();
    logic [snq_cfg_pkg::depd_width-1:0] exp_depd;
    logic [snq_cfg_pkg::depd_width-1:0] masks [3];
    masks[0] = 10'b00_0000_0001;
    masks[1] = 10'b00_0100_0000;
    masks[2] = 10'b00_0000_0010;
    // both vbs and one wmb entry
    exp_depd = 10'b00_0100_0011;
    create_entry(random_addr(), exp_depd, snq_proto_pkg::read_shared);
    check_value("rd_tag_rdy", 64'(rd_tag_rdy), 64'(1'b0));
    check_value("depd_vb_id", 64'(depd_vb_id), 64'(exp_depd[1:0]));
    for (int i = 0; i < 3; i++)
    begin
      next_cycle();
      depd_remove = masks[i];
      next_cycle();
      depd_remove = '0;
      exp_depd    = exp_depd & ~masks[i];
      settle();
      check_value("rd_tag_rdy", 64'(rd_tag_rdy), 64'(exp_depd == '0));
      check_value("depd_vb_id", 64'(depd_vb_id), 64'(exp_depd[1:0]));
    end
  endtask

  task automatic test_read_shared_dirty();
    create_entry(random_addr(), '0, snq_proto_pkg::read_shared);
    issue_tag();
    // valid, dirty, not shared, way 1
    return_tag(snq_proto_pkg::tag_resp_t'(4'b1101), 1'b0);
    // read_data, chg_tag_s and chg_tag
    check_value("need", 64'(need), 64'(4'b1101));
    check_value("way", 64'(way), 64'(1'b1));
    // not oldest yet, so no data request
    repeat (2)
    begin
      check_value("snpdt_start", 64'(snpdt_start), 64'(1'b0));
      next_cycle();
      settle();
    end
    next_cycle();
    oldest = 1'b1;
    run_data_stage();
    wait_for_strobe(1'b1, "cr_resp_valid");
    // is_shared, pass_dirty, data_transfer
    check_value("cr_resp", 64'(cr_resp), 64'(5'b01101));
    pop_response();
  endtask

  task automatic test_read_once_clean();
    create_entry(random_addr(), '0, snq_proto_pkg::read_once);
    issue_tag();
    // valid, clean, shared, with an ecc error
    return_tag(snq_proto_pkg::tag_resp_t'(4'b1010), 1'b1);
    check_value("need", 64'(need), 64'(4'b0000));
    check_value("cr_resp_valid", 64'(cr_resp_valid), 64'(1'b0));
    next_cycle();
    oldest = 1'b1;
    settle();
    check_value("cr_resp_valid", 64'(cr_resp_valid), 64'(1'b1));
    // is_shared and error only
    check_value("cr_resp", 64'(cr_resp), 64'(5'b01010));
    next_cycle();
    oldest = 1'b0;
    settle();
    check_value("cr_resp_valid", 64'(cr_resp_valid), 64'(1'b0));
    next_cycle();
    oldest = 1'b1;
    wait_for_strobe(1'b1, "cr_resp_valid");
    pop_response();
  endtask

  task automatic test_vb_wait_make_invalid();
    create_entry(random_addr(), '0, snq_proto_pkg::make_invalid);
    check_value("tag_req_for_inv", 64'(tag_req_for_inv), 64'(1'b1));
    next_cycle();
    vb_start_wait = 1'b1;
    vb_wait_id    = 2'b11;
    next_cycle();
    vb_start_wait = 1'b0;
    vb_wait_id    = '0;
    issue_tag();
    return_tag(snq_proto_pkg::tag_resp_t'(4'b1011), 1'b0);
    // chg_tag_i and chg_tag
    check_value("need", 64'(need), 64'(4'b0011));
    next_cycle();
    oldest = 1'b1;
    run_data_stage();
    // first vb drains, second still pending
    for (int i = 0; i < 2; i++)
    begin
      repeat (3)
      begin
        next_cycle();
        settle();
        check_value("cr_resp_valid", 64'(cr_resp_valid), 64'(1'b0));
      end
      next_cycle();
      vb_wait_remove = (i == 0) ? 2'b01 : 2'b10;
      next_cycle();
      vb_wait_remove = '0;
    end
    wait_for_strobe(1'b1, "cr_resp_valid");
    check_value("cr_resp", 64'(cr_resp), 64'(5'b00000));
    pop_response();
  endtask

  task automatic test_index_compare();
    logic [snq_cfg_pkg::pa_width-1:0] a;
    logic [snq_cfg_pkg::pa_width-1:0] near;
    logic [snq_cfg_pkg::pa_width-1:0] far;
    int                               k;
    repeat (4)
    begin
      a = random_addr();
      // entry depends on wmb entries 0 and 1
      create_entry(a, 10'b00_0000_1100, snq_proto_pkg::read_once);
      near       = random_addr();
      near[13:6] = a[13:6];
      k          = $urandom_range(7);
      far        = near;
      far[6 + k] = ~far[6 + k];
      compare_index(near, near, near, 8'b0000_0100, 3'b111);
      // only pointers the entry waits on
      compare_index(near, near, near, 8'b0000_0011, 3'b011);
      compare_index(near, near, near, 8'b0000_0111, 3'b111);
      compare_index(far, far, far, 8'b0000_0100, 3'b000);
      compare_index(far, near, far, 8'b0000_0100, 3'b010);
    end
  endtask

  initial
  begin
    void'($urandom(77447));
    err_cnt  = 0;
    cpurst_b = 1'b0;
    {create_en, vb_start_wait, tag_start, tag_grnt, resp_create_en, ecc_err,
     snpdt_grnt, snpdt_cmplt, oldest, cr_resp_accept} = '0;
    {create, depd_remove, vb_wait_id, vb_wait_remove, tag_resp} = '0;
    {wmb_write_addr, wmb_write_ptr, wmb_read_addr, lfb_vb_addr_tto6} = '0;
    repeat (4) @(posedge snqctrlclk);
    #1;
    cpurst_b = 1'b1;
    test_reset_create();
    test_dependencies();
    test_read_shared_dirty();
    test_read_once_clean();
    test_vb_wait_make_invalid();
    test_index_compare();
    if (err_cnt == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

// ==== compile.f ====
hdl/snq_cfg_pkg.sv
hdl/snq_proto_pkg.sv
hdl/snq_entry_ctrl.sv
hdl/snq_depd_track.sv
hdl/snq_resp_decode.sv
hdl/snq_addr_match.sv
hdl/snq_entry_top.sv
tests/snq_entry_sva.sv
tests/tb_snq_entry.sv

// ==== Makefile ====
SIM      = verilator
SIMFLAGS = --binary --timing --assert
TOP      = tb_snq_entry
FILELIST = compile.f

BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "test passed" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
